// ==== hw/sp_pkg.sv ====
`default_nettype none

package sp_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    // host pipe and trigger words are 16 bits
    localparam int PIPE_W = 16;
    // one waveform sample is a float, two pipe words
    localparam int SAMPLE_W = 2 * PIPE_W;
    // rate half-count, wide enough for 2*half+1
    localparam int HALF_CNT_W = 18;

    //////////////////////////////////////////////////
    // waveform buffer geometry
    //////////////////////////////////////////////////
    localparam int WAVE_ADDR_W = 5;
    localparam int WAVE_DEPTH = 1 << WAVE_ADDR_W;

    // half-count after global reset, tick every 8 cycles
    localparam int DEFAULT_HALF_CNT = 3;

    typedef logic [PIPE_W-1:0] pipe_word_t;
    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [HALF_CNT_W-1:0] half_cnt_t;
    typedef logic [WAVE_ADDR_W-1:0] wave_addr_t;
    // one bit more than the address so a full buffer is representable
    typedef logic [WAVE_ADDR_W:0] wave_count_t;

    // playback control
    typedef enum logic {
        WAIT_SAMPLES,
        PLAYING
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/wave_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface wave_if
    import sp_pkg::*;
();

    // write side, from the packer
    logic        wr_en;
    wave_addr_t  wr_addr;
    sample_t     wr_data;
    // number of samples stored so far
    wave_count_t count;

    // read side, from the controller
    logic        rd_en;
    wave_addr_t  rd_addr;

    modport packer (
        output wr_en,
        output wr_addr,
        output wr_data,
        output count
    );

    modport ctrl (
        input  count,
        output rd_en,
        output rd_addr
    );

    modport buffer (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_en,
        input  rd_addr
    );

endinterface

`default_nettype wire

// ==== hw/sim_rate_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module sim_rate_ctrl
    import sp_pkg::*;
(
    input  logic       ep50trig,
    input  logic       reset_global,
    input  logic       i_reset_sim,
    input  logic       i_rate_load,
    input  pipe_word_t i_rate_word,
    output logic       o_sim_tick,
    wave_if.ctrl       wave
);

    half_cnt_t   half_cnt;
    half_cnt_t   cycle_cnt;
    half_cnt_t   period_last;
    logic        sim_tick;
    ctrl_state_t state;
    wave_addr_t  rd_ptr;
    wave_count_t rd_ptr_inc;

    //////////////////////////////////////////////////
    // rate register and tick generator
    //////////////////////////////////////////////////

    // last count value of a period, 2*(half+1)-1
    // half is loaded from 16 bits so the shift never overflows
    assign period_last = {half_cnt[HALF_CNT_W-2:0], 1'b1};

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            half_cnt <= half_cnt_t'(DEFAULT_HALF_CNT);
            cycle_cnt <= '0;
            sim_tick <= 1'b0;
        end
        else if (i_rate_load)
        begin
            // new rate, restart the period from here
            half_cnt <= half_cnt_t'(i_rate_word);
            cycle_cnt <= '0;
            sim_tick <= 1'b0;
        end
        else if (cycle_cnt == period_last)
        begin
            cycle_cnt <= '0;
            sim_tick <= 1'b1;
        end
        else
        begin
            cycle_cnt <= cycle_cnt + 1'b1;
            sim_tick <= 1'b0;
        end
    end

    // sim reset leaves the rate and the counter running
    assign o_sim_tick = sim_tick;

    //////////////////////////////////////////////////
    // playback FSM and read pointer
    //////////////////////////////////////////////////

    // pointer one ahead, in count width for the wrap test
    assign rd_ptr_inc = wave_count_t'(rd_ptr) + 1'b1;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_reset_sim)
        begin
            state <= WAIT_SAMPLES;
            rd_ptr <= '0;
        end
        else
        begin
            case (state)
                WAIT_SAMPLES:
                begin
                    // first packed sample has landed
                    if (wave.count != '0)
                        state <= PLAYING;
                end
                PLAYING:
                begin
                    if (sim_tick)
                    begin
                        // wrap at the number of stored samples
                        if (rd_ptr_inc == wave.count)
                            rd_ptr <= '0;
                        else
                            rd_ptr <= rd_ptr + 1'b1;
                    end
                end
                default:
                    state <= WAIT_SAMPLES;
            endcase
        end
    end

    // pop one sample per tick while playing
    assign wave.rd_en = sim_tick && (state == PLAYING);
    assign wave.rd_addr = rd_ptr;

endmodule

`default_nettype wire

// ==== hw/pipe_word_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_word_packer
    import sp_pkg::*;
(
    input  logic       ep50trig,
    input  logic       reset_global,
    input  logic       i_reset_sim,
    input  logic       i_pipe_write,
    input  pipe_word_t i_pipe_data,
    wave_if.packer     wave
);

    // 0 waits for low word, 1 waits for high word
    logic        phase;
    pipe_word_t  low_word;
    logic        wr_en_q;
    sample_t     sample_q;
    wave_count_t sample_count;
    logic        buf_full;

    assign buf_full = (sample_count == wave_count_t'(WAVE_DEPTH));

    //////////////////////////////////////////////////
    // pairing and count
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_reset_sim)
        begin
            phase <= 1'b0;
            wr_en_q <= 1'b0;
            sample_count <= '0;
        end
        else
        begin
            // write issued last cycle, bump the count now
            if (wr_en_q)
                sample_count <= sample_count + 1'b1;
            // second word of a pair starts a write
            wr_en_q <= i_pipe_write && !buf_full && phase;
            // words against a full buffer are dropped
            if (i_pipe_write && !buf_full)
                phase <= ~phase;
        end
    end

    // payload only, no reset
    always_ff @(posedge ep50trig)
    begin
        if (i_pipe_write && !phase)
            low_word <= i_pipe_data;
        if (i_pipe_write && phase)
            sample_q <= {i_pipe_data, low_word};
    end

    // next free slot is the current count
    assign wave.wr_en = wr_en_q;
    assign wave.wr_addr = sample_count[WAVE_ADDR_W-1:0];
    assign wave.wr_data = sample_q;
    assign wave.count = sample_count;

endmodule

`default_nettype wire

// ==== hw/wave_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module wave_buffer
    import sp_pkg::*;
(
    input  logic    ep50trig,
    input  logic    reset_global,
    input  logic    i_reset_sim,
    wave_if.buffer  wave,
    output sample_t o_wave
);

    // stored waveform, written once per packed pair
    sample_t mem [WAVE_DEPTH];
    sample_t wave_q;

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (wave.wr_en)
            mem[wave.wr_addr] <= wave.wr_data;
    end

    //////////////////////////////////////////////////
    // registered read port
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_reset_sim)
        begin
            // output reads zero until the first pop
            wave_q <= '0;
        end
        else if (wave.rd_en)
        begin
            // sample shows one cycle after the tick
            wave_q <= mem[wave.rd_addr];
        end
    end

    // holds between pops
    assign o_wave = wave_q;

endmodule

`default_nettype wire

// ==== hw/spindle_stim_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module spindle_stim_top
    import sp_pkg::*;
(
    input  logic       ep50trig,
    input  logic       reset_global,
    input  logic       i_reset_sim,
    input  logic       i_rate_load,
    input  pipe_word_t i_rate_word,
    input  logic       i_pipe_write,
    input  pipe_word_t i_pipe_data,
    output logic       o_sim_tick,
    output sample_t    o_wave
);

    //////////////////////////////////////////////////
    // buffer bus between packer, controller, memory
    //////////////////////////////////////////////////
    wave_if wave_bus ();

    // rate register, tick and playback pointer
    sim_rate_ctrl sim_rate_ctrl_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_rate_load  (i_rate_load),
        .i_rate_word  (i_rate_word),
        .o_sim_tick   (o_sim_tick),
        .wave         (wave_bus.ctrl)
    );

    // host pipe words, two per sample
    pipe_word_packer pipe_word_packer_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_pipe_write (i_pipe_write),
        .i_pipe_data  (i_pipe_data),
        .wave         (wave_bus.packer)
    );

    // sample store and waveform output
    wave_buffer wave_buffer_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .wave         (wave_bus.buffer),
        .o_wave       (o_wave)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
(
    output logic ep50trig,
    output logic reset_global
);

    // 8 ns period
    initial
    begin
        ep50trig = 1'b0;
        forever
            #4 ep50trig = ~ep50trig;
    end

    // held over two rising edges, released with the input skew
    initial
    begin
        reset_global = 1'b1;
        repeat (2)
            @(posedge ep50trig);
        #1;
        reset_global = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/spindle_stim_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module spindle_stim_properties
    import sp_pkg::*;
(
    input logic    ep50trig,
    input logic    reset_global,
    input logic    i_reset_sim,
    input logic    i_sim_tick,
    input sample_t i_wave
);

    //////////////////////////////////////////////////
    // tick shape
    //////////////////////////////////////////////////

    // one-cycle pulse, even at the shortest period
    tick_one_cycle: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        i_sim_tick |=> !i_sim_tick
    )
    else
        $error("sim tick high for two cycles in a row");

    // no tick right after a global reset
    tick_low_after_reset: assert property (
        @(posedge ep50trig)
        reset_global |=> !i_sim_tick
    )
    else
        $error("sim tick high in the cycle after reset_global");

    //////////////////////////////////////////////////
    // waveform output
    //////////////////////////////////////////////////

    // moves only on a pop or a sim reset clear
    wave_moves_on_pop: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        $changed(i_wave) |-> ($past(i_sim_tick) || $past(i_reset_sim))
    )
    else
        $error("waveform output changed without a preceding tick");

endmodule

bind spindle_stim_top spindle_stim_properties spindle_stim_properties_i (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .i_reset_sim  (i_reset_sim),
    .i_sim_tick   (o_sim_tick),
    .i_wave       (o_wave)
);

`default_nettype wire

// ==== verification/spindle_stim_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module spindle_stim_tb
    import sp_pkg::*;
();

    logic       ep50trig;
    logic       reset_global;
    logic       reset_sim;
    logic       rate_load;
    pipe_word_t rate_word;
    logic       pipe_write;
    pipe_word_t pipe_data;
    logic       sim_tick;
    sample_t    wave;

    // current record
    string      kind;
    string      test_name;
    int         half;
    pipe_word_t words[$];
    sample_t    expect_q[$];

    int fd;
    int timeout_cycles = 4096;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_bad = 0;

    tb_clock_gen clock_gen_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global)
    );

    spindle_stim_top spindle_stim_top_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (reset_sim),
        .i_rate_load  (rate_load),
        .i_rate_word  (rate_word),
        .i_pipe_write (pipe_write),
        .i_pipe_data  (pipe_data),
        .o_sim_tick   (sim_tick),
        .o_wave       (wave)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("abort in test %s: %s", test_name, reason);
        $display("Verification failed");
        $finish;
    endtask

    // tick period from the half-count
    function automatic int period_of(input int h);
        return 2 * (h + 1);
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        checks++;
        if (act_val !== exp_val)
        begin
            errors++;
            test_errors++;
            $display("FAIL %s: %s expected %h actual %h", test_name, what, exp_val, act_val);
        end
    endtask

    // negedges up to and including the next tick cycle
    task automatic await_tick(output int cycles);
        cycles = 0;
        do
        begin
            @(negedge ep50trig);
            cycles++;
            if (cycles > timeout_cycles)
                abort_run("no sim tick arrived within the timeout");
        end
        while (!sim_tick);
    endtask

    task automatic drive_idle(input int n);
        repeat (n)
        begin
            @(posedge ep50trig);
            #1;
            pipe_write = 1'b0;
        end
    endtask

    task automatic load_rate(input pipe_word_t word);
        @(posedge ep50trig);
        #1;
        rate_load = 1'b1;
        rate_word = word;
        @(posedge ep50trig);
        #1;
        rate_load = 1'b0;
    endtask

    task automatic pulse_sim_reset();
        @(posedge ep50trig);
        #1;
        reset_sim = 1'b1;
        @(posedge ep50trig);
        #1;
        reset_sim = 1'b0;
    endtask

    // one word per write cycle, random idle gaps
    task automatic stream_words();
        foreach (words[k])
        begin
            drive_idle(int'($urandom % 3));
            @(posedge ep50trig);
            #1;
            pipe_write = 1'b1;
            pipe_data = words[k];
        end
        drive_idle(1);
    endtask

    // skips comment lines, then reads one record
    task automatic read_record(output bit found);
        string tok;
        string rest;
        int n;
        int r;
        pipe_word_t w;
        sample_t s;
        found = 1'b0;
        words.delete();
        expect_q.delete();
        while (!found && $fscanf(fd, "%s", tok) == 1)
        begin
            if (tok.substr(0, 0) == "#")
                r = $fgets(rest, fd);
            else
                found = 1'b1;
        end
        if (found)
        begin
            kind = tok;
            if ($fscanf(fd, "%s %h %d", test_name, half, n) != 3)
                abort_run("malformed record header in the tests file");
            repeat (n)
            begin
                r = $fscanf(fd, "%h", w);
                words.push_back(w);
            end
            r = $fscanf(fd, "%d", n);
            repeat (n)
            begin
                r = $fscanf(fd, "%h", s);
                expect_q.push_back(s);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // test kinds
    //////////////////////////////////////////////////

    // no rate load yet, reset rate must hold
    task automatic run_default();
        int cycles;
        await_tick(cycles);
        repeat (3)
        begin
            await_tick(cycles);
            check_value("tick gap", period_of(half), cycles);
        end
    endtask

    task automatic run_play();
        int cycles;
        // park the tick so no pop happens while streaming
        load_rate(16'hffff);
        pulse_sim_reset();
        stream_words();
        load_rate(pipe_word_t'(half));
        await_tick(cycles);
        check_value("first tick delay", period_of(half), cycles - 1);
        // two extra pops show the wrap
        for (int i = 0; i < expect_q.size() + 2; i++)
        begin
            if (i > 0)
            begin
                await_tick(cycles);
                check_value("tick gap", period_of(half), cycles + 1);
            end
            @(negedge ep50trig);
            check_value($sformatf("sample %0d", i), expect_q[i % expect_q.size()], wave);
        end
    endtask

    task automatic run_empty();
        int cycles;
        pulse_sim_reset();
        load_rate(pipe_word_t'(half));
        await_tick(cycles);
        repeat (4)
        begin
            @(negedge ep50trig);
            check_value("wave with no samples", 0, wave);
            await_tick(cycles);
            check_value("tick gap", period_of(half), cycles + 1);
        end
    endtask

    task automatic watch_first_sample();
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge ep50trig);
            cycles++;
            if (cycles > timeout_cycles)
                abort_run("new waveform never reached the output");
        end
        while (wave == '0);
        check_value("first sample after sim reset", expect_q[0], wave);
    endtask

    // previous waveform still playing at the rate of this record
    task automatic run_simrst();
        int cycles;
        await_tick(cycles);
        pulse_sim_reset();
        @(negedge ep50trig);
        check_value("wave after sim reset", 0, wave);
        await_tick(cycles);
        await_tick(cycles);
        check_value("tick gap after sim reset", period_of(half), cycles);
        check_value("wave before new samples", 0, wave);
        fork
            stream_words();
            watch_first_sample();
        join
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial
    begin
        bit found;
        int cycles;
        int unsigned seed_val;
        reset_sim = 1'b0;
        rate_load = 1'b0;
        rate_word = '0;
        pipe_write = 1'b0;
        pipe_data = '0;
        test_name = "setup";
        seed_val = $urandom(32'hb8eb_9462);
        fd = $fopen("verification/spindle_stim_tests.txt", "r");
        if (fd == 0)
            abort_run("cannot open the tests file");
        cycles = 0;
        @(negedge ep50trig);
        while (reset_global)
        begin
            @(negedge ep50trig);
            cycles++;
            if (cycles > 16)
                abort_run("reset_global was never released");
        end
        read_record(found);
        while (found)
        begin
            test_errors = 0;
            if (kind == "default")
                run_default();
            else if (kind == "play")
                run_play();
            else if (kind == "empty")
                run_empty();
            else if (kind == "simrst")
                run_simrst();
            else
                abort_run("unknown test kind in the tests file");
            tests_run++;
            if (test_errors == 0)
                $display("test %-14s ok", test_name);
            else
            begin
                tests_bad++;
                $display("test %-14s %0d mismatches", test_name, test_errors);
            end
            read_record(found);
        end
        $fclose(fd);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0 && tests_run > 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/sp_pkg.sv
hw/wave_if.sv
hw/sim_rate_ctrl.sv
hw/pipe_word_packer.sv
hw/wave_buffer.sv
hw/spindle_stim_top.sv
verification/tb_clock_gen.sv
verification/spindle_stim_properties.sv
verification/spindle_stim_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the spindle stimulus testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f compile.f \
    --top-module spindle_stim_tb \
    -o spindle_stim_sim

./obj_dir/spindle_stim_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation clean, see sim.log"
exit 0

// ==== verification/spindle_stim_tests.txt ====
# kind name half_cnt(hex) n_words(dec) pipe_words(hex) n_samples(dec) samples in play order(hex)
# kinds are default, play, empty and simrst; each pair is low word then high word
default reset_rate 3 0 0
play ramp4 5 8 1111 2222 3333 4444 5555 6666 7777 8888
    4 22221111 44443333 66665555 88887777
play single_fast 0 2 beef dead 1 deadbeef
play float_three 9 6 0000 3f80 0000 4000 0000 4120 3 3f800000 40000000 41200000
empty no_samples 2 0 0
# 34 pairs streamed, only the first 32 fit in the buffer
play full_buffer 1 68
    a000 b000 a001 b001 a002 b002 a003 b003 a004 b004 a005 b005
    a006 b006 a007 b007 a008 b008 a009 b009 a00a b00a a00b b00b
    a00c b00c a00d b00d a00e b00e a00f b00f a010 b010 a011 b011
    a012 b012 a013 b013 a014 b014 a015 b015 a016 b016 a017 b017
    a018 b018 a019 b019 a01a b01a a01b b01b a01c b01c a01d b01d
    a01e b01e a01f b01f a020 b020 a021 b021
    32 b000a000 b001a001 b002a002 b003a003 b004a004 b005a005 b006a006 b007a007
    b008a008 b009a009 b00aa00a b00ba00b b00ca00c b00da00d b00ea00e b00fa00f
    b010a010 b011a011 b012a012 b013a013 b014a014 b015a015 b016a016 b017a017
    b018a018 b019a019 b01aa01a b01ba01b b01ca01c b01da01d b01ea01e b01fa01f
simrst sim_reset 1 4 5a5a c3c3 0f0f f0f0 1 c3c35a5a
